// File: src/spi_frame_pkg.sv
package spi_frame_pkg;

  // spi frame layout as sent by the mcu
  // first bit on the wire is the msb of the frame word

  // a valid frame is exactly this many sclk edges
  localparam int FRAME_BITS = 16;

  // high byte selects the register
  localparam int ADDR_BITS = 8;

  // low byte carries the value
  localparam int DATA_BITS = 8;

  // one bit wider than a full frame needs
  // so a 17th edge is still visible as overrun
  localparam int COUNT_BITS = 5;

  // frame word bit positions
  localparam int ADDR_MSB = FRAME_BITS - 1;
  localparam int DATA_MSB = DATA_BITS - 1;

endpackage

// File: src/regmap_pkg.sv
package regmap_pkg;

  // control register addresses, matched against the frame high byte
  localparam logic [7:0] ADDR_LED = 8'd7;
  localparam logic [7:0] ADDR_MUX = 8'd8;
  localparam logic [7:0] ADDR_DAC = 8'd9;

  // peripheral select mask, one bit per routed slave select
  localparam int MUX_BITS = 8;

  // led register
  localparam int LED_BITS = 8;

  // dac control
  // bit 0 ldac, bit 1 reset, bit 2 uni/bip a, bit 3 uni/bip b
  localparam int DAC_BITS = 4;

  // values after reset
  // empty mask means no peripheral is ever selected
  localparam logic [MUX_BITS-1:0] MUX_RESET = '0;
  localparam logic [LED_BITS-1:0] LED_RESET = '0;
  localparam logic [DAC_BITS-1:0] DAC_RESET = '0;

endpackage

// File: src/spi_events_if.sv
`timescale 1ns/10ps

interface spi_events_if;

  // one-cycle pulse per rising sclk edge inside a frame
  logic sclk_rise;

  // one-cycle pulses on ss_n falling and rising edges
  logic frame_start;
  logic frame_end;

  // mosi sample, valid together with sclk_rise
  logic mosi_bit;

  // kind of the current frame, held for the whole frame
  logic special_lvl;

  // driven by the front end only
  modport source (
    output sclk_rise,
    output frame_start,
    output frame_end,
    output mosi_bit,
    output special_lvl
  );

  // frame fsm, bit counter and shifter
  modport sink (
    input sclk_rise,
    input frame_start,
    input frame_end,
    input mosi_bit,
    input special_lvl
  );

endinterface

// File: src/spi_front_end.sv
`timescale 1ns/10ps

module spi_front_end #(
  parameter int SYNC_STAGES = 2
) (
  input  logic        cs,
  input  logic        rst,
  input  logic        sclk,
  input  logic        ss_n,
  input  logic        mosi,
  input  logic        special,
  spi_events_if.source ev
);

  // pin vector order {special, mosi, ss_n, sclk}
  localparam logic [3:0] PIN_IDLE = 4'b0010;

  logic [3:0]                   pins;
  logic [SYNC_STAGES-1:0][3:0]  sync_q;
  logic [3:0]                   pins_s;
  logic                         sclk_s;
  logic                         ss_s;
  logic                         mosi_s;
  logic                         special_s;
  logic                         sclk_prev;
  logic                         ss_prev;

  assign pins = {special, mosi, ss_n, sclk};

  // last stage of the chain is the synchronized copy
  assign pins_s    = sync_q[SYNC_STAGES-1];
  assign sclk_s    = pins_s[0];
  assign ss_s      = pins_s[1];
  assign mosi_s    = pins_s[2];
  assign special_s = pins_s[3];

  // synchronizer chain, all four pins in lockstep
  // reset to idle bus levels so no edge fires after reset
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sync_q <= {SYNC_STAGES{PIN_IDLE}};
    end
    else
    begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], pins};
    end
  end

  // edge detect against previous synchronized value
  // events are registered, so a pin edge shows up SYNC_STAGES+1 cycles later
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      sclk_prev      <= 1'b0;
      ss_prev        <= 1'b1;
      ev.sclk_rise   <= 1'b0;
      ev.frame_start <= 1'b0;
      ev.frame_end   <= 1'b0;
      ev.mosi_bit    <= 1'b0;
      ev.special_lvl <= 1'b0;
    end
    else
    begin
      sclk_prev      <= sclk_s;
      ss_prev        <= ss_s;
      // sclk edges only count while selected
      ev.sclk_rise   <= sclk_s & ~sclk_prev & ~ss_s;
      ev.frame_start <= ss_prev & ~ss_s;
      ev.frame_end   <= ~ss_prev & ss_s;
      ev.mosi_bit    <= mosi_s;
      // frame kind latched at select, fixed until the next frame
      if (ss_prev && !ss_s)
      begin
        ev.special_lvl <= special_s;
      end
    end
  end

endmodule

// File: src/bit_counter.sv
`timescale 1ns/10ps

module bit_counter
  import spi_frame_pkg::*;
(
  input  logic                  cs,
  input  logic                  rst,
  input  logic                  clear,
  spi_events_if.sink            ev,
  output logic [COUNT_BITS-1:0] bit_count,
  output logic                  overrun
);

  localparam logic [COUNT_BITS-1:0] COUNT_MAX  = '1;
  localparam logic [COUNT_BITS-1:0] COUNT_FULL = COUNT_BITS'(FRAME_BITS);

  // counts sclk edges in the current frame
  // saturates so a very long frame cannot wrap back to 16
  always_ff @(posedge cs)
  begin
    if (rst || clear)
    begin
      bit_count <= '0;
      overrun   <= 1'b0;
    end
    else if (ev.sclk_rise)
    begin
      if (bit_count != COUNT_MAX)
      begin
        bit_count <= bit_count + 1'b1;
      end
      // edge beyond a full frame, sticky until the next frame
      if (bit_count >= COUNT_FULL)
      begin
        overrun <= 1'b1;
      end
    end
  end

endmodule

// File: src/frame_shifter.sv
`timescale 1ns/10ps

module frame_shifter
  import spi_frame_pkg::*;
(
  input  logic                  cs,
  input  logic                  rst,
  input  logic                  clear,
  spi_events_if.sink            ev,
  output logic [FRAME_BITS-1:0] frame_word
);

  // msb first on the wire
  // shifting in at the lsb leaves the first bit at the top
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      frame_word <= '0;
    end
    else if (clear)
    begin
      // short frame must not pick up bits of the previous one
      frame_word <= '0;
    end
    else if (ev.sclk_rise)
    begin
      frame_word <= {frame_word[FRAME_BITS-2:0], ev.mosi_bit};
    end
  end

endmodule

// File: src/frame_fsm.sv
`timescale 1ns/10ps

module frame_fsm
  import spi_frame_pkg::*;
(
  input  logic                  cs,
  input  logic                  rst,
  spi_events_if.sink            ev,
  input  logic [COUNT_BITS-1:0] bit_count,
  input  logic                  overrun,
  output logic                  clear,
  output logic                  commit_pulse,
  output logic                  route_active,
  output logic                  frame_error
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ROUTE,
    ST_CHECK
  } state_t;

  state_t state;
  state_t state_next;
  state_t start_state;
  logic   frame_ok;
  logic   frame_ok_q;

  // exact length, no extra edge seen
  assign frame_ok = (bit_count == COUNT_BITS'(FRAME_BITS)) && !overrun;

  // special frames route, everything else writes a register
  assign start_state = ev.special_lvl ? ST_ROUTE : ST_WRITE;

  // counter and shifter restart with every frame
  assign clear = ev.frame_start;

  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
      begin
        if (ev.frame_start)
        begin
          state_next = start_state;
        end
      end
      ST_WRITE:
      begin
        if (ev.frame_end)
        begin
          state_next = ST_CHECK;
        end
      end
      // no commit at the end of a routed frame
      ST_ROUTE:
      begin
        if (ev.frame_end)
        begin
          state_next = ST_IDLE;
        end
      end
      // one cycle only, verdict is on the outputs here
      ST_CHECK:
      begin
        state_next = ev.frame_start ? start_state : ST_IDLE;
      end
      default:
      begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      frame_ok_q <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // length verdict taken at ss_n rise, before anything can move the count
      if (state == ST_WRITE && ev.frame_end)
      begin
        frame_ok_q <= frame_ok;
      end
    end
  end

  // pulses land exactly one cycle after frame_end
  assign commit_pulse = (state == ST_CHECK) && frame_ok_q;
  assign frame_error  = (state == ST_CHECK) && !frame_ok_q;
  assign route_active = (state == ST_ROUTE);

endmodule

// File: src/control_regs.sv
`timescale 1ns/10ps

module control_regs
  import spi_frame_pkg::*;
  import regmap_pkg::*;
(
  input  logic                  cs,
  input  logic                  rst,
  input  logic                  commit_pulse,
  input  logic [FRAME_BITS-1:0] frame_word,
  output logic [MUX_BITS-1:0]   reg_mux,
  output logic [LED_BITS-1:0]   reg_led,
  output logic [DAC_BITS-1:0]   reg_dac
);

  logic [ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0] data;

  // high byte is the register, low byte the value
  assign addr = frame_word[ADDR_MSB -: ADDR_BITS];
  assign data = frame_word[DATA_MSB:0];

  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      reg_mux <= MUX_RESET;
      reg_led <= LED_RESET;
      reg_dac <= DAC_RESET;
    end
    else if (commit_pulse)
    begin
      case (addr)
        // peripheral select mask
        ADDR_MUX:
        begin
          reg_mux <= data[MUX_BITS-1:0];
        end
        ADDR_LED:
        begin
          reg_led <= data[LED_BITS-1:0];
        end
        // only the low nibble reaches the dac pins
        ADDR_DAC:
        begin
          reg_dac <= data[DAC_BITS-1:0];
        end
        // unknown address, silently ignored
        default:
        begin
          reg_mux <= reg_mux;
        end
      endcase
    end
  end

endmodule

// File: src/select_router.sv
`timescale 1ns/10ps

module select_router
  import regmap_pkg::*;
(
  input  logic                cs,
  input  logic                rst,
  input  logic                route_active,
  input  logic [MUX_BITS-1:0] reg_mux,
  output logic [MUX_BITS-1:0] periph_ss_n
);

  logic [MUX_BITS-1:0] select;

  // a peripheral is selected only during a routed frame
  // and only if its mask bit is set
  assign select = reg_mux & {MUX_BITS{route_active}};

  // registered so the selects never glitch while mask or state settle
  always_ff @(posedge cs)
  begin
    if (rst)
    begin
      // nothing selected
      periph_ss_n <= '1;
    end
    else
    begin
      periph_ss_n <= ~select;
    end
  end

endmodule

// File: src/spi_ctrl_top.sv
`timescale 1ns/10ps

module spi_ctrl_top
  import spi_frame_pkg::*;
  import regmap_pkg::*;
#(
  // 2 or 3 flops on each spi pin
  parameter int SYNC_STAGES = 2
) (
  input  logic                cs,
  input  logic                rst,
  input  logic                sclk,
  input  logic                ss_n,
  input  logic                mosi,
  input  logic                special,
  output logic [LED_BITS-1:0] led,
  // bit 0 ldac, bit 1 reset, bit 2 uni/bip a, bit 3 uni/bip b
  output logic [DAC_BITS-1:0] dac_ctrl,
  // active low, bit 0 adc, bit 1 dac on the board
  output logic [MUX_BITS-1:0] periph_ss_n,
  output logic                frame_error
);

  logic                  clear;
  logic                  commit_pulse;
  logic                  route_active;
  logic [COUNT_BITS-1:0] bit_count;
  logic                  overrun;
  logic [FRAME_BITS-1:0] frame_word;
  logic [MUX_BITS-1:0]   reg_mux;

  // synchronized spi events, front end to frame logic
  spi_events_if ev_if ();

  spi_front_end #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_front_end (
    .cs      (cs),
    .rst     (rst),
    .sclk    (sclk),
    .ss_n    (ss_n),
    .mosi    (mosi),
    .special (special),
    .ev      (ev_if.source)
  );

  bit_counter i_bit_counter (
    .cs        (cs),
    .rst       (rst),
    .clear     (clear),
    .ev        (ev_if.sink),
    .bit_count (bit_count),
    .overrun   (overrun)
  );

  frame_shifter i_frame_shifter (
    .cs         (cs),
    .rst        (rst),
    .clear      (clear),
    .ev         (ev_if.sink),
    .frame_word (frame_word)
  );

  frame_fsm i_frame_fsm (
    .cs           (cs),
    .rst          (rst),
    .ev           (ev_if.sink),
    .bit_count    (bit_count),
    .overrun      (overrun),
    .clear        (clear),
    .commit_pulse (commit_pulse),
    .route_active (route_active),
    .frame_error  (frame_error)
  );

  // led and dac registers go straight to the pins
  control_regs i_control_regs (
    .cs           (cs),
    .rst          (rst),
    .commit_pulse (commit_pulse),
    .frame_word   (frame_word),
    .reg_mux      (reg_mux),
    .reg_led      (led),
    .reg_dac      (dac_ctrl)
  );

  select_router i_select_router (
    .cs           (cs),
    .rst          (rst),
    .route_active (route_active),
    .reg_mux      (reg_mux),
    .periph_ss_n  (periph_ss_n)
  );

endmodule

// File: verification/spi_ctrl_checker.sv
`timescale 1ns/10ps

module spi_ctrl_checker (
  input logic cs,
  input logic rst,
  input logic frame_end,
  input logic commit_pulse,
  input logic frame_error
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  // a frame gets one verdict, never both
  a_exclusive: assert property (@(posedge cs) disable iff (rst)
    !(commit_pulse && frame_error))
    else
    begin
      fail_count++;
      $error("commit_pulse and frame_error high in the same cycle");
    end

  // commit lasts one cycle
  a_commit_single: assert property (@(posedge cs) disable iff (rst)
    commit_pulse |=> !commit_pulse)
    else
    begin
      fail_count++;
      $error("commit_pulse longer than one cycle");
    end

  // error lasts one cycle
  a_error_single: assert property (@(posedge cs) disable iff (rst)
    frame_error |=> !frame_error)
    else
    begin
      fail_count++;
      $error("frame_error longer than one cycle");
    end

  // verdict lands exactly one cycle after ss_n rise event
  a_verdict_timing: assert property (@(posedge cs) disable iff (rst)
    (commit_pulse || frame_error) |-> $past(frame_end))
    else
    begin
      fail_count++;
      $error("verdict pulse without frame_end one cycle earlier");
    end

endmodule

// File: verification/tb_spi_ctrl.sv
`timescale 1ns/10ps

module tb_spi_ctrl
  import spi_frame_pkg::*;
  import regmap_pkg::*;
();

  localparam int SYNC_STAGES = 2;
  localparam int CLK_HALF    = 20;
  // input change after the rising edge
  localparam int DRIVE_DELAY = 2;
  // sclk half period in cs cycles
  localparam int HALF        = 3;
  // idle cycles between frames
  localparam int GAP         = 10;
  // outputs may lag a pin edge by this many cycles
  localparam int SETTLE      = 7;
  // 12 frames of about 110 cycles plus margin
  localparam int MAX_CYCLES  = 4000;

  logic                cs;
  logic                rst;
  logic                sclk;
  logic                ss_n;
  logic                mosi;
  logic                special;
  logic [LED_BITS-1:0] led;
  logic [DAC_BITS-1:0] dac_ctrl;
  logic [MUX_BITS-1:0] periph_ss_n;
  logic                frame_error;

  // model of what the dut should show
  logic [LED_BITS-1:0] exp_led;
  logic [DAC_BITS-1:0] exp_dac;
  logic [MUX_BITS-1:0] exp_mux;
  logic [MUX_BITS-1:0] exp_ss;
  int                  exp_err_pulses = 0;
  int                  err_pulses = 0;
  int                  cycle = 0;
  int                  quiet_until = 0;
  int                  errors = 0;
  int                  chk_errors;
  logic                quiet;

  spi_ctrl_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_dut (
    .cs          (cs),
    .rst         (rst),
    .sclk        (sclk),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .special     (special),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .periph_ss_n (periph_ss_n),
    .frame_error (frame_error)
  );

  // fsm handshake checks
  bind frame_fsm spi_ctrl_checker i_checker (
    .cs           (cs),
    .rst          (rst),
    .frame_end    (ev.frame_end),
    .commit_pulse (commit_pulse),
    .frame_error  (frame_error)
  );

  always #CLK_HALF cs = ~cs;

  // cycle count, error pulse count and run limit
  always @(posedge cs)
  begin
    cycle <= cycle + 1;
    if (!rst && frame_error)
    begin
      err_pulses <= err_pulses + 1;
    end
    if (cycle >= MAX_CYCLES)
    begin
      $display("run stopped at cycle %0d, frames did not finish in time", cycle);
      $display("Testbench failed");
      $finish;
    end
  end

  // checks off in reset and while outputs follow a pin edge
  assign quiet = rst || (cycle < quiet_until);

  a_led: assert property (@(posedge cs) !quiet |-> led == exp_led)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: led expected %h, got %h",
               $time, $sampled(exp_led), $sampled(led));
    end

  a_dac: assert property (@(posedge cs) !quiet |-> dac_ctrl == exp_dac)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: dac_ctrl expected %h, got %h",
               $time, $sampled(exp_dac), $sampled(dac_ctrl));
    end

  // mask register only visible through routing
  a_select: assert property (@(posedge cs) !quiet |-> periph_ss_n == exp_ss)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: periph_ss_n expected %h, got %h",
               $time, $sampled(exp_ss), $sampled(periph_ss_n));
    end

  // one pulse per bad frame and none otherwise
  a_error_count: assert property (@(posedge cs) !quiet |-> err_pulses == exp_err_pulses)
    else
    begin
      errors++;
      $display("[FAIL] %0t ns: frame_error pulses expected %0d, got %0d",
               $time, $sampled(exp_err_pulses), $sampled(err_pulses));
    end

  // wait n edges and step past the last one
  task automatic hold(input int n);
    repeat (n)
    begin
      @(posedge cs);
      #DRIVE_DELAY;
    end
  endtask

  // register write rules
  // dac keeps only the low nibble
  task automatic apply_write(input logic [ADDR_BITS-1:0] addr,
                             input logic [DATA_BITS-1:0] data);
    case (addr)
      ADDR_LED: exp_led = data[LED_BITS-1:0];
      ADDR_MUX: exp_mux = data[MUX_BITS-1:0];
      ADDR_DAC: exp_dac = data[DAC_BITS-1:0];
      default:  exp_led = exp_led;
    endcase
  endtask

  // msb first in spi mode 0
  // only the lowest nbits of bits go out
  task automatic send_frame(input logic [FRAME_BITS:0] bits,
                            input int nbits,
                            input logic spec);
    int i;
    hold(1);
    ss_n    = 1'b0;
    special = spec;
    sclk    = 1'b0;
    if (spec)
    begin
      // masked selects drop once the fsm is in route state
      exp_ss      = ~exp_mux;
      quiet_until = cycle + SETTLE;
    end
    for (i = nbits - 1; i >= 0; i--)
    begin
      mosi = bits[i];
      sclk = 1'b0;
      hold(HALF);
      sclk = 1'b1;
      hold(HALF);
    end
    sclk = 1'b0;
    mosi = 1'b0;
    hold(HALF);
    ss_n        = 1'b1;
    special     = 1'b0;
    quiet_until = cycle + SETTLE;
    exp_ss      = '1;
    // special frames never write
    if (!spec)
    begin
      if (nbits == FRAME_BITS)
      begin
        apply_write(bits[ADDR_MSB -: ADDR_BITS], bits[DATA_MSB:0]);
      end
      else
      begin
        exp_err_pulses++;
      end
    end
    hold(GAP);
  endtask

  task automatic write_reg(input logic [ADDR_BITS-1:0] addr,
                           input logic [DATA_BITS-1:0] data);
    send_frame({1'b0, addr, data}, FRAME_BITS, 1'b0);
  endtask

  task automatic route_frame(input logic [FRAME_BITS-1:0] word);
    send_frame({1'b0, word}, FRAME_BITS, 1'b1);
  endtask

  initial
  begin
    logic [DATA_BITS-1:0] data;
    logic [ADDR_BITS-1:0] addr;
    logic [MUX_BITS-1:0]  mask;
    cs      = 1'b0;
    rst     = 1'b1;
    sclk    = 1'b0;
    ss_n    = 1'b1;
    mosi    = 1'b0;
    special = 1'b0;
    exp_led = LED_RESET;
    exp_dac = DAC_RESET;
    exp_mux = MUX_RESET;
    exp_ss  = '1;
    void'($urandom(13));
    hold(2);
    rst = 1'b0;
    // reset values are checked from here on
    hold(4);

    data = 8'($urandom());
    write_reg(ADDR_LED, data);
    // full byte sent but only four bits kept
    data = 8'($urandom());
    write_reg(ADDR_DAC, data | 8'hf0);
    // mask with both set and clear bits
    mask = {1'b0, 6'($urandom()), 1'b1};
    write_reg(ADDR_MUX, mask);
    route_frame(16'($urandom()));

    // unknown address leaves every register alone
    addr = 8'($urandom()) | 8'h10;
    write_reg(addr, 8'($urandom()));
    // 15 bits that still leave a led write in the zero-filled word
    data = 8'($urandom());
    send_frame({2'b00, ADDR_LED[ADDR_BITS-2:0], data}, FRAME_BITS - 1, 1'b0);
    // 17 bits whose last 16 look like a led write
    data = 8'($urandom());
    send_frame({1'b1, ADDR_LED, data}, FRAME_BITS + 1, 1'b0);
    // routed frame that looks like a led write
    route_frame({ADDR_LED, 8'($urandom())});

    mask = {6'($urandom()), 2'b10};
    write_reg(ADDR_MUX, mask);
    route_frame({ADDR_DAC, 8'($urandom())});
    write_reg(ADDR_LED, 8'($urandom()));
    write_reg(ADDR_DAC, 8'($urandom()));

    hold(SETTLE + 4);
    chk_errors = i_dut.i_frame_fsm.i_checker.fail_count;
    $display("errors: output checks %0d, fsm checks %0d", errors, chk_errors);
    if (errors == 0 && chk_errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/spi_frame_pkg.sv
src/regmap_pkg.sv
src/spi_events_if.sv
src/spi_front_end.sv
src/bit_counter.sv
src/frame_shifter.sv
src/frame_fsm.sv
src/control_regs.sv
src/select_router.sv
src/spi_ctrl_top.sv
verification/spi_ctrl_checker.sv
verification/tb_spi_ctrl.sv
